/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module top_vga_tb \
    -f src.f -o top_vga_sim

# a crash or an aborted run counts as a failure too.
./obj_dir/top_vga_sim > sim.log 2>&1 || echo "SIMULATION FAILED" >> sim.log
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run_sim: failure found in sim.log"
    exit 1
fi
echo "run_sim: no failure found in sim.log"
exit 0

/* sim/top_vga_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module top_vga_assertions (
    input logic clk,
    input logic rst_n,
    input logic hs,
    input logic psel,
    input logic penable
);
    import vga_pkg::*;

    logic [10:0] hs_len;

    // length of the current hs pulse in clocks.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_len <= '0;
        end else if (hs) begin
            hs_len <= hs_len + 11'd1;
        end else begin
            hs_len <= '0;
        end
    end

    hs_width_ok: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(hs) |-> (hs_len == h_sync))
        else $error("hs pulse was %0d clocks long", hs_len);

    setup_then_access: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && !penable) |=> (psel && penable))
        else $error("apb access phase did not follow the setup phase");

    enable_needs_select: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else $error("penable high without psel");

endmodule

bind top_vga top_vga_assertions u_top_vga_assertions (
    .clk(clk),
    .rst_n(rst_n),
    .hs(hs),
    .psel(psel),
    .penable(penable)
);

`default_nettype wire

/* sim/top_vga_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module top_vga_tb;
    import vga_pkg::*;

    localparam int clk_period   = 4;
    localparam int line_cycles  = int'(h_total);
    localparam int v_lines      = int'(v_total);
    localparam int frame_cycles = line_cycles * v_lines;
    localparam int h_vis        = int'(h_visible);
    localparam int v_vis        = int'(v_visible);
    localparam int h_sync_at    = int'(h_sync_start);
    localparam int v_sync_at    = int'(v_sync_start);
    // six frames of tests plus a few lines of slack.
    localparam int watchdog_cycles = 6 * frame_cycles + 8 * line_cycles;

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        hs;
    logic        vs;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;

    integer seed = 32'hff7f_1bcb;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_errors = 0;
    string  test_name;

    int     rect_x;
    int     rect_y;
    int     rect_w;
    int     rect_h;
    rgb_t   bg_col;
    rgb_t   char_col;

    // raster position seen at the ports, rebuilt from the sync edges.
    int     px = 0;
    int     py = 0;
    int     cyc = 0;
    logic   pos_valid = 1'b0;
    logic   hs_q = 1'b0;
    logic   vs_q = 1'b0;
    rgb_t   cur_rgb;
    logic   hs_seen = 1'b0;
    logic   vs_seen = 1'b0;
    int     hs_rise_at = 0;
    int     vs_rise_at = 0;
    int     hs_width = 0;
    int     vs_width = 0;
    int     line_period = 0;
    int     frame_period = 0;
    logic   watch_over = 1'b0;
    logic   saw_over = 1'b0;

    top_vga u_top_vga (
        .clk(clk),
        .rst_n(rst_n),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .hs(hs),
        .vs(vs),
        .r(r),
        .g(g),
        .b(b)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: the tests did not finish in the expected number of frames");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // pixel sampler.
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        cyc = cyc + 1;
        cur_rgb = {r, g, b};
        if (!rst_n) begin
            pos_valid = 1'b0;
        end else if (vs && !vs_q) begin
            // vs rises on the first pixel of its line.
            pos_valid = 1'b1;
            px = 0;
            py = v_sync_at;
        end else if (hs && !hs_q) begin
            px = h_sync_at;
        end else begin
            px = px + 1;
            if (px == line_cycles) begin
                px = 0;
                py = (py == v_lines - 1) ? 0 : py + 1;
            end
        end
        if (rst_n && hs && !hs_q) begin
            if (hs_seen) begin
                line_period = cyc - hs_rise_at;
            end
            hs_seen = 1'b1;
            hs_rise_at = cyc;
        end
        if (rst_n && !hs && hs_q && hs_seen) begin
            hs_width = cyc - hs_rise_at;
        end
        if (rst_n && vs && !vs_q) begin
            if (vs_seen) begin
                frame_period = cyc - vs_rise_at;
            end
            vs_seen = 1'b1;
            vs_rise_at = cyc;
        end
        if (rst_n && !vs && vs_q && vs_seen) begin
            vs_width = cyc - vs_rise_at;
        end
        if (watch_over && (u_top_vga.game_state == st_over)) begin
            saw_over = 1'b1;
        end
        hs_q = hs;
        vs_q = vs;
    end

    function automatic int rand_range(input int lo, input int span);
        logic [31:0] raw;
        raw = $random(seed);
        return lo + int'(raw % 32'(span));
    endfunction

    // colour that the pixel at x, y must have.
    function automatic rgb_t expected_rgb(input game_state_t st, input int x, input int y,
                                          input int cx, input int cy, input int cw,
                                          input int ch, input rgb_t bg, input rgb_t chr);
        rgb_t col;
        if (x >= h_vis || y >= v_vis) begin
            col = '0;
        end else begin
            case (st)
                st_play: col = bg;
                st_over: col = over_rgb;
                default: col = menu_rgb;
            endcase
            if (st == st_play && x >= cx && x < cx + cw && y >= cy && y < cy + ch) begin
                col = chr;
            end
        end
        return col;
    endfunction

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input game_state_t exp,
                               input game_state_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // apb master.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk);
        #1;
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            errors++;
            $display("error: apb access to %h was never completed by pready", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic write_and_verify(input string name, input logic [7:0] addr,
                                    input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_write(addr, data, err);
        check_flag({name, " write error"}, 1'b0, err);
        apb_read(addr, rd, err);
        check_word({name, " readback"}, data, rd);
    endtask

    task automatic expect_status(input string name, input game_state_t exp);
        logic [31:0] rd;
        logic        err;
        apb_read(reg_status, rd, err);
        check_state(name, exp, game_state_t'(rd[1:0]));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // raster helpers.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic wait_pos(input int x, input int y, output rgb_t col);
        int n;
        n = 0;
        @(posedge clk);
        while (!(pos_valid && px == x && py == y) && n < 2 * frame_cycles) begin
            @(posedge clk);
            n++;
        end
        if (n >= 2 * frame_cycles) begin
            errors++;
            $display("error: pixel position (%0d,%0d) was never reached", x, y);
        end
        col = cur_rgb;
    endtask

    task automatic wait_frame_start();
        rgb_t unused;
        wait_pos(0, 0, unused);
    endtask

    // rectangle corners and edges in raster order, then one point in each blank.
    task automatic scan_points(input string name, input game_state_t st);
        int   xs[11];
        int   ys[11];
        rgb_t act;
        int   x1;
        int   y1;
        x1 = rect_x + rect_w;
        y1 = rect_y + rect_h;
        xs = '{rect_x - 1, rect_x, x1 - 1, x1, h_vis + 100,
               rect_x - 1, rect_x, x1 - 1, x1, rect_x, 100};
        ys = '{rect_y, rect_y, rect_y, rect_y, rect_y,
               y1 - 1, y1 - 1, y1 - 1, y1 - 1, y1, v_vis + 10};
        for (int i = 0; i < 11; i++) begin
            wait_pos(xs[i], ys[i], act);
            check_rgb($sformatf("%s pixel (%0d,%0d)", name, xs[i], ys[i]),
                      expected_rgb(st, xs[i], ys[i], rect_x, rect_y, rect_w, rect_h,
                                   bg_col, char_col),
                      act);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    initial begin
        apb_word_u   word;
        logic [31:0] rd;
        logic        err;
        rgb_t        pix;
        int          n;

        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        rect_x   = rand_range(1, 600);
        rect_y   = rand_range(1, 400);
        rect_w   = rand_range(8, 143);
        rect_h   = rand_range(8, 143);
        bg_col   = rgb_t'(rand_range(0, 4096));
        char_col = rgb_t'(rand_range(0, 4096));
        if (char_col == bg_col) begin
            char_col = ~bg_col;
        end

        start_test("registers");
        expect_status("status after reset", st_menu);
        apb_read(8'h40, rd, err);
        check_flag("unmapped read error", 1'b1, err);
        word = '0;
        word.xy.x = 12'(rect_x);
        word.xy.y = 12'(rect_y);
        write_and_verify("pos", reg_pos, word);
        word.xy.x = 12'(rect_w);
        word.xy.y = 12'(rect_h);
        write_and_verify("size", reg_size, word);
        word = '0;
        word.col.rgb = bg_col;
        write_and_verify("bg", reg_bg, word);
        word.col.rgb = char_col;
        write_and_verify("char", reg_char, word);
        write_and_verify("round", reg_round, 32'd2);
        apb_write(reg_status, 32'd1, err);
        check_flag("status write error", 1'b1, err);
        expect_status("status after status write", st_menu);
        finish_test();

        start_test("menu picture");
        wait_frame_start();
        scan_points("menu", st_menu);
        finish_test();

        start_test("play picture");
        apb_write(reg_ctrl, 32'd1, err);
        expect_status("status after start", st_play);
        wait_frame_start();
        scan_points("play", st_play);
        finish_test();

        start_test("round end");
        expect_status("status after one frame", st_play);
        wait_frame_start();
        n = 0;
        apb_read(reg_status, rd, err);
        while (game_state_t'(rd[1:0]) != st_over && n < 32) begin
            apb_read(reg_status, rd, err);
            n++;
        end
        check_state("status after two frames", st_over, game_state_t'(rd[1:0]));
        scan_points("over", st_over);
        finish_test();

        start_test("return to menu");
        apb_write(reg_ctrl, 32'd2, err);
        expect_status("status after menu write", st_menu);
        apb_write(reg_ctrl, 32'd1, err);
        expect_status("status after second start", st_play);
        watch_over = 1'b1;
        wait_frame_start();
        wait_pos(0, v_vis / 2, pix);
        apb_write(reg_ctrl, 32'd2, err);
        expect_status("status after abandoned round", st_menu);
        wait_frame_start();
        wait_pos(16, 0, pix);
        expect_status("status one frame later", st_menu);
        watch_over = 1'b0;
        check_flag("over seen in abandoned round", 1'b0, saw_over);
        finish_test();

        start_test("sync timing");
        check_word("hs width", 32'(int'(h_sync)), 32'(hs_width));
        check_word("line period", 32'(line_cycles), 32'(line_period));
        check_word("vs width", 32'(int'(v_sync) * line_cycles), 32'(vs_width));
        check_word("frame period", 32'(frame_cycles), 32'(frame_period));
        finish_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/vga_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/round_timer.sv
src/game_fsm.sv
src/game_regs.sv
src/draw_bg.sv
src/draw_rect.sv
src/top_vga.sv
sim/top_vga_assertions.sv
sim/top_vga_tb.sv

/* src/draw_bg.sv */
`timescale 1ns/1ps
`default_nettype none

module draw_bg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vga_pkg::game_state_t game_state,
    input  vga_pkg::rgb_t        bg_rgb,
    vga_if.in                    vga_in,
    vga_if.out                   vga_out
);
    import vga_pkg::*;

    rgb_t rgb_nxt;

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = '0;
        end else begin
            case (game_state)
                st_play: rgb_nxt = bg_rgb;
                st_over: rgb_nxt = over_rgb;
                default: rgb_nxt = menu_rgb;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* src/draw_rect.sv */
`timescale 1ns/1ps
`default_nettype none

module draw_rect (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vga_pkg::game_state_t game_state,
    input  logic [11:0]          char_x,
    input  logic [11:0]          char_y,
    input  logic [11:0]          char_w,
    input  logic [11:0]          char_h,
    input  vga_pkg::rgb_t        char_rgb,
    vga_if.in                    vga_in,
    vga_if.out                   vga_out
);
    import vga_pkg::*;

    // one extra bit keeps the right and bottom edges from wrapping.
    logic [12:0] hpos;
    logic [12:0] vpos;
    logic [12:0] x_end;
    logic [12:0] y_end;
    logic        in_x;
    logic        in_y;
    logic        visible;
    rgb_t        rgb_nxt;

    assign hpos  = {2'b00, vga_in.hcount};
    assign vpos  = {2'b00, vga_in.vcount};
    assign x_end = {1'b0, char_x} + {1'b0, char_w};
    assign y_end = {1'b0, char_y} + {1'b0, char_h};

    assign in_x    = (hpos >= {1'b0, char_x}) && (hpos < x_end);
    assign in_y    = (vpos >= {1'b0, char_y}) && (vpos < y_end);
    assign visible = !vga_in.hblnk && !vga_in.vblnk;

    always_comb begin
        rgb_nxt = vga_in.rgb;
        if ((game_state == st_play) && visible && in_x && in_y) begin
            rgb_nxt = char_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* src/game_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_req,
    input  logic                 menu_req,
    input  logic                 round_done,
    output vga_pkg::game_state_t game_state
);
    import vga_pkg::*;

    game_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            game_state <= st_menu;
        end else begin
            game_state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = game_state;
        // menu request overrides everything else.
        if (menu_req) begin
            state_nxt = st_menu;
        end else begin
            case (game_state)
                st_menu: begin
                    if (start_req) begin
                        state_nxt = st_play;
                    end
                end
                st_play: begin
                    if (round_done) begin
                        state_nxt = st_over;
                    end
                end
                st_over: state_nxt = st_over;
                default: state_nxt = st_menu;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/game_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module game_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  vga_pkg::game_state_t game_state,
    output logic                 start_req,
    output logic                 menu_req,
    output logic [11:0]          char_x,
    output logic [11:0]          char_y,
    output logic [11:0]          char_w,
    output logic [11:0]          char_h,
    output vga_pkg::rgb_t        bg_rgb,
    output vga_pkg::rgb_t        char_rgb,
    output logic [7:0]           round_frames
);
    import vga_pkg::*;

    apb_word_u wdata;
    apb_word_u rdata;
    logic      access;
    logic      wr_en;
    logic      addr_ok;

    assign wdata  = pwdata;
    assign access = psel && penable;
    assign wr_en  = access && pwrite && (paddr != reg_status);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_req    <= 1'b0;
            menu_req     <= 1'b0;
            char_x       <= '0;
            char_y       <= '0;
            char_w       <= '0;
            char_h       <= '0;
            bg_rgb       <= '0;
            char_rgb     <= '0;
            round_frames <= 8'd1;
        end else begin
            start_req <= wr_en && (paddr == reg_ctrl) && pwdata[0];
            menu_req  <= wr_en && (paddr == reg_ctrl) && pwdata[1];
            if (wr_en) begin
                case (paddr)
                    reg_pos: begin
                        char_x <= wdata.xy.x;
                        char_y <= wdata.xy.y;
                    end
                    reg_size: begin
                        char_w <= wdata.xy.x;
                        char_h <= wdata.xy.y;
                    end
                    reg_bg:    bg_rgb       <= wdata.col.rgb;
                    reg_char:  char_rgb     <= wdata.col.rgb;
                    reg_round: round_frames <= pwdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // readback and errors.
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (paddr)
            reg_ctrl: rdata = '0;
            reg_pos: begin
                rdata.xy.x = char_x;
                rdata.xy.y = char_y;
            end
            reg_size: begin
                rdata.xy.x = char_w;
                rdata.xy.y = char_h;
            end
            reg_bg:     rdata.col.rgb = bg_rgb;
            reg_char:   rdata.col.rgb = char_rgb;
            reg_round:  rdata = {24'd0, round_frames};
            reg_status: rdata = {30'd0, game_state};
            default:    addr_ok = 1'b0;
        endcase
    end

    assign prdata  = rdata;
    assign pready  = 1'b1;
    assign pslverr = access && (!addr_ok || (pwrite && (paddr == reg_status)));

endmodule

`default_nettype wire

/* src/round_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module round_timer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                frame_start,
    input  vga_pkg::game_state_t game_state,
    input  logic [7:0]          round_frames,
    output logic                round_done
);
    import vga_pkg::*;

    logic [7:0] frame_cnt;
    logic [7:0] frame_cnt_nxt;
    logic       in_play;

    assign in_play       = (game_state == st_play);
    assign frame_cnt_nxt = frame_cnt + 8'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt  <= '0;
            round_done <= 1'b0;
        end else begin
            round_done <= in_play && frame_start && (frame_cnt_nxt == round_frames);
            if (!in_play) begin
                frame_cnt <= '0;
            end else if (frame_start) begin
                frame_cnt <= frame_cnt_nxt;
            end
        end
    end

endmodule

`default_nettype wire

/* src/top_vga.sv */
`timescale 1ns/1ps
`default_nettype none

module top_vga (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        hs,
    output logic        vs,
    output logic [3:0]  r,
    output logic [3:0]  g,
    output logic [3:0]  b
);
    import vga_pkg::*;

    game_state_t game_state;
    logic        frame_start;
    logic        round_done;
    logic        start_req;
    logic        menu_req;
    logic [11:0] char_x;
    logic [11:0] char_y;
    logic [11:0] char_w;
    logic [11:0] char_h;
    rgb_t        bg_rgb;
    rgb_t        char_rgb;
    logic [7:0]  round_frames;

    vga_if vga_tim ();
    vga_if vga_bg ();
    vga_if vga_rect ();

    assign hs        = vga_rect.hsync;
    assign vs        = vga_rect.vsync;
    assign {r, g, b} = vga_rect.rgb;

    // ~~~~~~~~~~~~~~~~~~~~
    // control path.
    // ~~~~~~~~~~~~~~~~~~~~
    game_regs u_game_regs (
        .clk(clk),
        .rst_n(rst_n),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .game_state(game_state),
        .start_req(start_req),
        .menu_req(menu_req),
        .char_x(char_x),
        .char_y(char_y),
        .char_w(char_w),
        .char_h(char_h),
        .bg_rgb(bg_rgb),
        .char_rgb(char_rgb),
        .round_frames(round_frames)
    );

    game_fsm u_game_fsm (
        .clk(clk),
        .rst_n(rst_n),
        .start_req(start_req),
        .menu_req(menu_req),
        .round_done(round_done),
        .game_state(game_state)
    );

    round_timer u_round_timer (
        .clk(clk),
        .rst_n(rst_n),
        .frame_start(frame_start),
        .game_state(game_state),
        .round_frames(round_frames),
        .round_done(round_done)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // pixel pipeline.
    // ~~~~~~~~~~~~~~~~~~~~
    vga_timing u_vga_timing (
        .clk(clk),
        .rst_n(rst_n),
        .vga_out(vga_tim.out),
        .frame_start(frame_start)
    );

    draw_bg u_draw_bg (
        .clk(clk),
        .rst_n(rst_n),
        .game_state(game_state),
        .bg_rgb(bg_rgb),
        .vga_in(vga_tim.in),
        .vga_out(vga_bg.out)
    );

    draw_rect u_draw_rect (
        .clk(clk),
        .rst_n(rst_n),
        .game_state(game_state),
        .char_x(char_x),
        .char_y(char_y),
        .char_w(char_w),
        .char_h(char_h),
        .char_rgb(char_rgb),
        .vga_in(vga_bg.in),
        .vga_out(vga_rect.out)
    );

endmodule

`default_nettype wire

/* src/vga_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface vga_if;
    import vga_pkg::*;

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    rgb_t        rgb;

    modport out (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);
    modport in  (input  hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

endinterface

`default_nettype wire

/* src/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // 800x600 svga timing.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [10:0] h_visible    = 11'd800;
    localparam logic [10:0] h_front      = 11'd40;
    localparam logic [10:0] h_sync       = 11'd128;
    localparam logic [10:0] h_total      = 11'd1056;
    localparam logic [10:0] h_sync_start = h_visible + h_front;
    localparam logic [10:0] h_sync_end   = h_visible + h_front + h_sync;

    localparam logic [10:0] v_visible    = 11'd600;
    localparam logic [10:0] v_front      = 11'd1;
    localparam logic [10:0] v_sync       = 11'd4;
    localparam logic [10:0] v_total      = 11'd628;
    localparam logic [10:0] v_sync_start = v_visible + v_front;
    localparam logic [10:0] v_sync_end   = v_visible + v_front + v_sync;

    typedef logic [11:0] rgb_t;

    typedef enum logic [1:0] {
        st_menu,
        st_play,
        st_over
    } game_state_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // apb register map.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0] reg_ctrl   = 8'h00;
    localparam logic [7:0] reg_pos    = 8'h04;
    localparam logic [7:0] reg_size   = 8'h08;
    localparam logic [7:0] reg_bg     = 8'h0C;
    localparam logic [7:0] reg_char   = 8'h10;
    localparam logic [7:0] reg_round  = 8'h14;
    localparam logic [7:0] reg_status = 8'h18;

    localparam rgb_t menu_rgb = 12'h00F;
    localparam rgb_t over_rgb = 12'hF00;

    // one bus word, seen as a coordinate pair or as a colour.
    typedef union packed {
        struct packed {
            logic [3:0]  rsvd_y;
            logic [11:0] y;
            logic [3:0]  rsvd_x;
            logic [11:0] x;
        } xy;
        struct packed {
            logic [19:0] rsvd;
            rgb_t        rgb;
        } col;
    } apb_word_u;

endpackage

`default_nettype wire

/* src/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic clk,
    input  logic rst_n,
    vga_if.out   vga_out,
    output logic frame_start
);
    import vga_pkg::*;

    logic [10:0] hcount;
    logic [10:0] vcount;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == h_total - 11'd1) begin
            hcount <= '0;
            // last line of the frame wraps to the top.
            if (vcount == v_total - 11'd1) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 11'd1;
            end
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    assign vga_out.hcount = hcount;
    assign vga_out.vcount = vcount;
    assign vga_out.hblnk  = (hcount >= h_visible);
    assign vga_out.vblnk  = (vcount >= v_visible);
    assign vga_out.hsync  = (hcount >= h_sync_start) && (hcount < h_sync_end);
    assign vga_out.vsync  = (vcount >= v_sync_start) && (vcount < v_sync_end);

    // later stages paint the picture.
    assign vga_out.rgb = '0;

    assign frame_start = (hcount == 11'd0) && (vcount == 11'd0);

endmodule

`default_nettype wire
